/* l1_cache.f */
+incdir+.
l1_cache_pkg.sv
l1_ctrl_pkg.sv
l1_way_if.sv
l1_sram.sv
l1_cache_way.sv
l1_hit_select.sv
l1_fill_ctrl.sv
l1_snoop_ctrl.sv
l1_cache_top.sv
tb_l1_cache.sv

/* Makefile */
# Verilator build and run of the L1 cache testbench

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module tb_l1_cache -f l1_cache.f -o Vtb_l1_cache

run: build
	./obj_dir/Vtb_l1_cache > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Simulation FAILED" sim.log
	grep -q "Simulation PASSED" sim.log

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -Wall --top-module l1_cache_top -f l1_cache.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

/* tb_l1_cache.sv */
// Self-checking testbench for the L1 read cache.
// The memory model answers wrapping bursts with random gaps before each beat.
// Its data depends on the word address and a per-line version. The version
// is only bumped right after a snoop to that line.
`timescale 1ns/1ps

module tb_l1_cache;
	localparam int TIMEOUT = 2000;

	logic clk_i = 1'b0;
	logic rst_n = 1'b0;
	logic i_rd_valid = 1'b0;
	logic [31:0] i_rd_addr = '0;
	logic o_rd_ready;
	logic o_rd_data_valid;
	logic [31:0] o_rd_data;
	logic i_rd_data_ready = 1'b1;
	logic o_mem_ar_valid;
	logic [31:0] o_mem_ar_addr;
	logic i_mem_ar_ready = 1'b1;
	logic i_mem_r_valid = 1'b0;
	logic [31:0] i_mem_r_data = '0;
	logic o_mem_r_ready;
	logic i_snoop_valid = 1'b0;
	logic [31:0] i_snoop_addr = '0;
	logic o_snoop_stall;

	// memory model state with versions keyed by line address
	int unsigned version [logic [27:0]];
	int ar_count = 0;
	int beat_count = 0;
	logic [31:0] ar_addr = '0;
	logic [1:0] m_word = '0;
	int m_left = 0;
	int m_gap = 0;

	l1_cache_top UUT (
		.clk_i(clk_i),
		.rst_n(rst_n),
		.i_rd_valid(i_rd_valid),
		.i_rd_addr(i_rd_addr),
		.o_rd_ready(o_rd_ready),
		.o_rd_data_valid(o_rd_data_valid),
		.o_rd_data(o_rd_data),
		.i_rd_data_ready(i_rd_data_ready),
		.o_mem_ar_valid(o_mem_ar_valid),
		.o_mem_ar_addr(o_mem_ar_addr),
		.i_mem_ar_ready(i_mem_ar_ready),
		.i_mem_r_valid(i_mem_r_valid),
		.i_mem_r_data(i_mem_r_data),
		.o_mem_r_ready(o_mem_r_ready),
		.i_snoop_valid(i_snoop_valid),
		.i_snoop_addr(i_snoop_addr),
		.o_snoop_stall(o_snoop_stall)
	);

	always #5 clk_i = ~clk_i;

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic check_result(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		assert (exp === act) else
			fail_now($sformatf("CHECK FAILED %s expected 0x%h actual 0x%h", name, exp, act));
	endtask

	function automatic int unsigned version_of(input logic [31:0] addr);
		return version.exists(addr[31:4]) ? version[addr[31:4]] : 0;
	endfunction

	function automatic logic [31:0] model_word(input logic [31:0] addr);
		return {addr[31:2], 2'b00} ^ (32'h9e37_79b9 * version_of(addr)) ^ 32'h00c0_ffee;
	endfunction

	// memory slave returns one beat per gap with the critical word first
	always @(posedge clk_i) begin
		if (o_mem_ar_valid && i_mem_ar_ready) begin
			ar_count++;
			ar_addr = o_mem_ar_addr;
			m_word = o_mem_ar_addr[3:2];
			m_left = 4;
			m_gap = $urandom_range(3, 0);
		end
		if (i_mem_r_valid && o_mem_r_ready) begin
			// later beats must wait while the requester holds off beat 0
			assert (!(o_rd_data_valid && !i_rd_data_ready && m_left != 4)) else
				fail_now("memory beat accepted while the requested word was pending");
			beat_count++;
			m_word++;
			m_left--;
			m_gap = $urandom_range(3, 0);
			i_mem_r_valid <= 1'b0;
		end else if (m_left > 0 && !i_mem_r_valid) begin
			if (m_gap == 0) begin
				i_mem_r_valid <= 1'b1;
				i_mem_r_data <= model_word({ar_addr[31:4], m_word, 2'b00});
			end else begin
				m_gap--;
			end
		end
	end

	task automatic wait_idle();
		int n;
		n = 0;
		while (!o_rd_ready) begin
			@(posedge clk_i);
			n++;
			if (n > TIMEOUT) fail_now("controller did not return to idle");
		end
	endtask

	// stall is the number of cycles the data is held off once valid
	task automatic read_check(input string name, input logic [31:0] addr, input int stall,
			output int vlat);
		int n;
		int held;
		i_rd_addr <= addr;
		i_rd_valid <= 1'b1;
		i_rd_data_ready <= (stall == 0);
		n = 0;
		do begin
			@(posedge clk_i);
			n++;
			if (n > TIMEOUT) fail_now("read request was never accepted");
		end while (!o_rd_ready);
		i_rd_valid <= 1'b0;
		n = 0;
		held = 0;
		vlat = 0;
		do begin
			@(posedge clk_i);
			n++;
			if (n > TIMEOUT) fail_now("read data never returned");
			if (o_rd_data_valid && vlat == 0) vlat = n;
			if (o_rd_data_valid && !i_rd_data_ready) begin
				held++;
				if (held >= stall) i_rd_data_ready <= 1'b1;
			end
		end while (!(o_rd_data_valid && i_rd_data_ready));
		check_result(name, model_word(addr), o_rd_data);
		i_rd_data_ready <= 1'b1;
	endtask

	// snoop pulse and stall length check before the line changes in memory
	task automatic snoop_and_bump(input logic [31:0] addr);
		int n;
		int high;
		i_snoop_addr <= addr;
		i_snoop_valid <= 1'b1;
		@(posedge clk_i);
		i_snoop_valid <= 1'b0;
		n = 0;
		high = 0;
		do begin
			@(posedge clk_i);
			n++;
			if (n > TIMEOUT) fail_now("snoop stall never cleared");
			if (o_snoop_stall) high++;
		end while (o_snoop_stall);
		check_result("snoop stall cycles", 2, high);
		version[addr[31:4]] = version_of(addr) + 1;
	endtask

	initial begin
		int vlat;
		int ar0;
		int beat0;
		logic [31:0] addr;
		void'($urandom(79739));
		repeat (2) @(posedge clk_i);
		rst_n <= 1'b1;
		wait_idle();

		// cold miss takes one burst of four beats
		ar0 = ar_count;
		beat0 = beat_count;
		read_check("first miss data", 32'h0001_2238, 0, vlat);
		wait_idle();
		check_result("first miss bursts", 1, ar_count - ar0);
		check_result("first miss beats", 4, beat_count - beat0);
		check_result("first miss burst address", 32'h0001_2238, ar_addr);

		// same word again and then every word of the line
		ar0 = ar_count;
		for (int w = 0; w < 5; w++) begin
			addr = (w == 0) ? 32'h0001_2238 : {28'h0001223, 2'(w - 1), 2'b00};
			read_check("line hit data", addr, 0, vlat);
			check_result("hit data valid edge", 3, vlat);
		end
		wait_idle();
		check_result("hit bursts", 0, ar_count - ar0);

		// five tags in one set to force an eviction
		for (int t = 1; t <= 5; t++) begin
			read_check("same set data", {20'(t), 8'h5c, 2'(t), 2'b00}, 0, vlat);
		end
		wait_idle();
		ar0 = ar_count;
		read_check("same set reread data", {20'(1), 8'h5c, 2'(1), 2'b00}, 0, vlat);
		wait_idle();
		assert (ar_count - ar0 <= 1) else
			fail_now($sformatf("CHECK FAILED reread bursts expected at most 1 actual %0d",
				ar_count - ar0));

		// snoop drops the line so the next read refetches the new version
		snoop_and_bump(32'h0001_2238);
		ar0 = ar_count;
		read_check("data after snoop", 32'h0001_2234, 0, vlat);
		wait_idle();
		check_result("bursts after snoop", 1, ar_count - ar0);

		// requester holds off the critical word until the next beat is offered
		read_check("stalled miss data", 32'h0004_0574, 6 + $urandom_range(4, 0), vlat);
		wait_idle();

		// random reads in a small window with evictions and occasional snoops
		for (int i = 0; i < 80; i++) begin
			addr = {20'($urandom_range(5, 0)), 8'h40 + 8'($urandom_range(1, 0)),
				2'($urandom_range(3, 0)), 2'b00};
			if ($urandom_range(7, 0) == 0) begin
				wait_idle();
				snoop_and_bump(addr);
			end
			read_check("random read data", addr,
				($urandom_range(3, 0) == 0) ? int'($urandom_range(3, 1)) : 0, vlat);
		end
		wait_idle();
		$display("Simulation PASSED");
		$finish;
	end
endmodule

/* l1_cache_top.sv */
// Read-only set-associative L1 cache with snoop invalidation.
// Memory bursts are 4-beat wrapping reads of 32-bit words starting at the
// requested word; beats are counted, so no last flag is needed.
`timescale 1ns/1ps
`include "l1_cache_params.svh"

module l1_cache_top (
	input logic clk_i,
	input logic rst_n,
	input logic i_rd_valid,
	input logic [`L1_ADDR_W-1:0] i_rd_addr,
	output logic o_rd_ready,
	output logic o_rd_data_valid,
	output l1_cache_pkg::word_t o_rd_data,
	input logic i_rd_data_ready,
	output logic o_mem_ar_valid,
	output logic [`L1_ADDR_W-1:0] o_mem_ar_addr,
	input logic i_mem_ar_ready,
	input logic i_mem_r_valid,
	input l1_cache_pkg::word_t i_mem_r_data,
	output logic o_mem_r_ready,
	input logic i_snoop_valid,
	input logic [`L1_ADDR_W-1:0] i_snoop_addr,
	output logic o_snoop_stall
);
	import l1_cache_pkg::*;

	tag_t tag;
	word_sel_t word;
	logic hit;
	way_idx_t hit_way;
	word_t hit_word;
	way_idx_t victim;
	tag_t snoop_tag;
	logic snoop_hit;
	way_idx_t snoop_hit_way;

	l1_way_if way_bus [`L1_WAYS] ();

	l1_fill_ctrl u_fill (
		.clk_i(clk_i),
		.rst_n(rst_n),
		.i_rd_valid(i_rd_valid),
		.i_rd_addr(i_rd_addr),
		.o_rd_ready(o_rd_ready),
		.o_rd_data_valid(o_rd_data_valid),
		.o_rd_data(o_rd_data),
		.i_rd_data_ready(i_rd_data_ready),
		.o_mem_ar_valid(o_mem_ar_valid),
		.o_mem_ar_addr(o_mem_ar_addr),
		.i_mem_ar_ready(i_mem_ar_ready),
		.i_mem_r_valid(i_mem_r_valid),
		.i_mem_r_data(i_mem_r_data),
		.o_mem_r_ready(o_mem_r_ready),
		.i_snoop_valid(i_snoop_valid),
		.i_snoop_addr(i_snoop_addr),
		.ways(way_bus),
		.o_tag(tag),
		.o_word(word),
		.i_hit(hit),
		.i_hit_way(hit_way),
		.i_hit_word(hit_word),
		.i_victim(victim)
	);

	for (genvar g = 0; g < `L1_WAYS; g++) begin : g_way
		l1_cache_way u_way (
			.clk_i(clk_i),
			.bus(way_bus[g])
		);
	end

	l1_hit_select u_hit (
		.clk_i(clk_i),
		.rst_n(rst_n),
		.ways(way_bus),
		.i_tag(tag),
		.i_word(word),
		.i_snoop_tag(snoop_tag),
		.o_hit(hit),
		.o_hit_way(hit_way),
		.o_hit_word(hit_word),
		.o_victim(victim),
		.o_snoop_hit(snoop_hit),
		.o_snoop_hit_way(snoop_hit_way)
	);

	l1_snoop_ctrl u_snoop (
		.clk_i(clk_i),
		.rst_n(rst_n),
		.i_snoop_valid(i_snoop_valid),
		.i_snoop_addr(i_snoop_addr),
		.o_snoop_stall(o_snoop_stall),
		.ways(way_bus),
		.o_snoop_tag(snoop_tag),
		.i_snoop_hit(snoop_hit),
		.i_snoop_hit_way(snoop_hit_way)
	);
endmodule

/* l1_snoop_ctrl.sv */
// Snoop invalidation through the second tag port.
// A snoop pulse is only legal while o_snoop_stall is low; each takes 2 cycles.
`timescale 1ns/1ps
`include "l1_cache_params.svh"

module l1_snoop_ctrl (
	input logic clk_i,
	input logic rst_n,
	input logic i_snoop_valid,
	input logic [`L1_ADDR_W-1:0] i_snoop_addr,
	output logic o_snoop_stall,
	l1_way_if.snoop ways [`L1_WAYS],
	output l1_cache_pkg::tag_t o_snoop_tag,
	input logic i_snoop_hit,
	input l1_cache_pkg::way_idx_t i_snoop_hit_way
);
	import l1_cache_pkg::*;
	import l1_ctrl_pkg::*;

	snoop_state_e state_q;
	addr_fields_t sn_f;
	set_idx_t set_q;
	tag_t tag_q;

	assign sn_f = addr_fields_t'(i_snoop_addr);
	assign o_snoop_stall = (state_q != S_IDLE);
	assign o_snoop_tag = tag_q;

	for (genvar g = 0; g < `L1_WAYS; g++) begin : g_way
		assign ways[g].b_set = set_q;
		assign ways[g].b_inv = (state_q == S_CHECK) && i_snoop_hit &&
			i_snoop_hit_way == way_idx_t'(g);
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			state_q <= S_IDLE;
		end else begin
			case (state_q)
				S_IDLE: state_q <= i_snoop_valid ? S_READ : S_IDLE;
				// tag read is in flight
				S_READ: state_q <= S_CHECK;
				default: state_q <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (state_q == S_IDLE && i_snoop_valid) begin
			set_q <= sn_f.set;
			tag_q <= sn_f.tag;
		end
	end
endmodule

/* l1_fill_ctrl.sv */
// Request controller: reset tag sweep, hit response and wrapping line fill.
// The critical word is forwarded on beat 0; if the requester stalls it is held
// and the memory data channel is stalled until it is taken.
// A snoop to the set of a fill in flight makes the filled line invalid.
`timescale 1ns/1ps
`include "l1_cache_params.svh"

module l1_fill_ctrl (
	input logic clk_i,
	input logic rst_n,
	input logic i_rd_valid,
	input logic [`L1_ADDR_W-1:0] i_rd_addr,
	output logic o_rd_ready,
	output logic o_rd_data_valid,
	output l1_cache_pkg::word_t o_rd_data,
	input logic i_rd_data_ready,
	output logic o_mem_ar_valid,
	output logic [`L1_ADDR_W-1:0] o_mem_ar_addr,
	input logic i_mem_ar_ready,
	input logic i_mem_r_valid,
	input l1_cache_pkg::word_t i_mem_r_data,
	output logic o_mem_r_ready,
	input logic i_snoop_valid,
	input logic [`L1_ADDR_W-1:0] i_snoop_addr,
	l1_way_if.ctrl ways [`L1_WAYS],
	output l1_cache_pkg::tag_t o_tag,
	output l1_cache_pkg::word_sel_t o_word,
	input logic i_hit,
	input l1_cache_pkg::way_idx_t i_hit_way,
	input l1_cache_pkg::word_t i_hit_word,
	input l1_cache_pkg::way_idx_t i_victim
);
	import l1_cache_pkg::*;
	import l1_ctrl_pkg::*;

	fill_state_e state_q;
	set_idx_t set_q;
	word_sel_t beat_q;
	logic pend_q;
	tag_t tag_q;
	word_sel_t word_q;
	word_sel_t off_q;
	way_idx_t way_q;
	word_t hold_q;
	line_t line_q;
	line_t line_nx;
	addr_fields_t rd_f;
	addr_fields_t sn_f;
	addr_fields_t ar_f;
	tag_entry_t fill_entry;
	logic rd_fire;
	logic r_fire;
	logic last_beat;
	logic snoop_set_hit;

	assign rd_f = addr_fields_t'(i_rd_addr);
	assign sn_f = addr_fields_t'(i_snoop_addr);
	assign ar_f = '{tag: tag_q, set: set_q, word: word_q, byte_off: 2'b00};

	assign o_rd_ready = (state_q == IDLE);
	assign o_mem_ar_valid = (state_q == FILL_AR);
	assign o_mem_ar_addr = ar_f;
	assign o_mem_r_ready = (state_q == FILL_DATA);
	assign o_rd_data_valid = (state_q == HIT_RESP) || (state_q == FILL_STALL) ||
		(state_q == FILL_DATA && beat_q == '0 && i_mem_r_valid);
	assign o_rd_data = (state_q == FILL_DATA) ? i_mem_r_data : hold_q;
	assign o_tag = tag_q;
	assign o_word = word_q;

	assign rd_fire = i_rd_valid && o_rd_ready;
	assign r_fire = i_mem_r_valid && o_mem_r_ready;
	assign last_beat = r_fire && beat_q == word_sel_t'(`L1_WORDS - 1);
	assign snoop_set_hit = i_snoop_valid && sn_f.set == set_q;
	assign fill_entry = '{valid: pend_q && !snoop_set_hit, tag: tag_q};

	// current beat merged into the line being assembled
	always_comb begin
		line_nx = line_q;
		line_nx[off_q] = i_mem_r_data;
	end

	for (genvar g = 0; g < `L1_WAYS; g++) begin : g_way
		assign ways[g].a_set = set_q;
		// the sweep clears every way at once
		assign ways[g].tag_we = (state_q == INIT_A) || (state_q == INIT_B) ||
			(last_beat && way_q == way_idx_t'(g));
		assign ways[g].tag_wdata = fill_entry;
		assign ways[g].line_we = last_beat && way_q == way_idx_t'(g);
		assign ways[g].line_wdata = line_nx;
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			state_q <= INIT_A;
			set_q <= '0;
			beat_q <= '0;
			pend_q <= 1'b0;
		end else begin
			if (state_q != IDLE && snoop_set_hit) begin
				pend_q <= 1'b0;
			end
			if (r_fire) begin
				beat_q <= beat_q + 1'b1;
			end
			case (state_q)
				INIT_A: state_q <= INIT_B;
				INIT_B: begin
					if (set_q == '1) begin
						state_q <= IDLE;
					end else begin
						set_q <= set_q + 1'b1;
						state_q <= INIT_A;
					end
				end
				IDLE: begin
					if (rd_fire) begin
						state_q <= CHECK_A;
						set_q <= rd_f.set;
						// a snoop in the same cycle already targets this set
						pend_q <= !(i_snoop_valid && sn_f.set == rd_f.set);
					end
				end
				CHECK_A: state_q <= CHECK_B;
				CHECK_B: begin
					beat_q <= '0;
					state_q <= i_hit ? HIT_RESP : FILL_AR;
				end
				HIT_RESP: begin
					if (i_rd_data_ready) begin
						state_q <= IDLE;
					end
				end
				FILL_AR: begin
					if (i_mem_ar_ready) begin
						state_q <= FILL_DATA;
					end
				end
				FILL_DATA: begin
					if (last_beat) begin
						state_q <= IDLE;
					end else if (r_fire && beat_q == '0 && !i_rd_data_ready) begin
						state_q <= FILL_STALL;
					end
				end
				FILL_STALL: begin
					if (i_rd_data_ready) begin
						state_q <= FILL_DATA;
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// request fields and data path
	always_ff @(posedge clk_i) begin
		if (rd_fire) begin
			tag_q <= rd_f.tag;
			word_q <= rd_f.word;
			off_q <= rd_f.word;
		end
		if (state_q == CHECK_B) begin
			hold_q <= i_hit_word;
			// way this request reads or refills
			way_q <= i_hit ? i_hit_way : i_victim;
		end
		if (r_fire) begin
			line_q <= line_nx;
			off_q <= off_q + 1'b1;
			if (beat_q == '0) begin
				hold_q <= i_mem_r_data;
			end
		end
	end
endmodule

/* l1_hit_select.sv */
// Tag compare across all ways for the lookup port and the snoop port.
// At most one way should hold a given tag; with duplicates the highest way wins.
// Victim is the lowest invalid way, else a free-running rotating way.
`timescale 1ns/1ps
`include "l1_cache_params.svh"

module l1_hit_select (
	input logic clk_i,
	input logic rst_n,
	l1_way_if.sel ways [`L1_WAYS],
	input l1_cache_pkg::tag_t i_tag,
	input l1_cache_pkg::word_sel_t i_word,
	input l1_cache_pkg::tag_t i_snoop_tag,
	output logic o_hit,
	output l1_cache_pkg::way_idx_t o_hit_way,
	output l1_cache_pkg::word_t o_hit_word,
	output l1_cache_pkg::way_idx_t o_victim,
	output logic o_snoop_hit,
	output l1_cache_pkg::way_idx_t o_snoop_hit_way
);
	import l1_cache_pkg::*;

	tag_entry_t a_tag [`L1_WAYS];
	line_t a_line [`L1_WAYS];
	tag_entry_t b_tag [`L1_WAYS];
	way_idx_t rot_q;

	for (genvar g = 0; g < `L1_WAYS; g++) begin : g_tap
		assign a_tag[g] = ways[g].a_tag;
		assign a_line[g] = ways[g].a_line;
		assign b_tag[g] = ways[g].b_tag;
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			rot_q <= '0;
		end else begin
			rot_q <= rot_q + 1'b1;
		end
	end

	always_comb begin
		o_hit = 1'b0;
		o_hit_way = '0;
		o_snoop_hit = 1'b0;
		o_snoop_hit_way = '0;
		o_victim = rot_q;
		for (int i = 0; i < `L1_WAYS; i++) begin
			if (a_tag[i].valid && a_tag[i].tag == i_tag) begin
				o_hit = 1'b1;
				o_hit_way = way_idx_t'(i);
			end
			if (b_tag[i].valid && b_tag[i].tag == i_snoop_tag) begin
				o_snoop_hit = 1'b1;
				o_snoop_hit_way = way_idx_t'(i);
			end
		end
		// scan downwards so the lowest invalid way is the last one kept
		for (int i = `L1_WAYS - 1; i >= 0; i--) begin
			if (!a_tag[i].valid) begin
				o_victim = way_idx_t'(i);
			end
		end
	end

	assign o_hit_word = a_line[o_hit_way][i_word];
endmodule

/* l1_cache_way.sv */
// One cache way: a tag memory and a line memory indexed by set.
// The line memory's second port is not used.
`timescale 1ns/1ps
`include "l1_cache_params.svh"

module l1_cache_way (
	input logic clk_i,
	l1_way_if.way bus
);
	import l1_cache_pkg::*;

	// snoop writes always clear the entry
	l1_sram #(.entry_t(tag_entry_t), .depth(`L1_SETS)) u_tag (
		.clk_i(clk_i),
		.i_addr_a(bus.a_set),
		.i_we_a(bus.tag_we),
		.i_wdata_a(bus.tag_wdata),
		.o_rdata_a(bus.a_tag),
		.i_addr_b(bus.b_set),
		.i_we_b(bus.b_inv),
		.i_wdata_b(tag_entry_t'('0)),
		.o_rdata_b(bus.b_tag)
	);

	l1_sram #(.entry_t(line_t), .depth(`L1_SETS)) u_line (
		.clk_i(clk_i),
		.i_addr_a(bus.a_set),
		.i_we_a(bus.line_we),
		.i_wdata_a(bus.line_wdata),
		.o_rdata_a(bus.a_line),
		.i_addr_b(bus.b_set),
		.i_we_b(1'b0),
		.i_wdata_b(line_t'('0)),
		.o_rdata_b()
	);
endmodule

/* l1_sram.sv */
// Two-port memory with registered reads, no reset on the contents.
// Reads return the old contents on a same-port write. If both ports
// write the same entry in one cycle, port B wins.
`timescale 1ns/1ps

module l1_sram #(
	parameter type entry_t = logic,
	parameter int depth = 256
) (
	input logic clk_i,
	input l1_cache_pkg::set_idx_t i_addr_a,
	input logic i_we_a,
	input entry_t i_wdata_a,
	output entry_t o_rdata_a,
	input l1_cache_pkg::set_idx_t i_addr_b,
	input logic i_we_b,
	input entry_t i_wdata_b,
	output entry_t o_rdata_b
);
	entry_t mem [depth];

	always_ff @(posedge clk_i) begin
		if (i_we_a) begin
			mem[i_addr_a] <= i_wdata_a;
		end
		if (i_we_b) begin
			mem[i_addr_b] <= i_wdata_b;
		end
		o_rdata_a <= mem[i_addr_a];
		o_rdata_b <= mem[i_addr_b];
	end
endmodule

/* l1_way_if.sv */
// Connection to one cache way.
// Port A is the fill and lookup path, port B is the snoop tag path.
`timescale 1ns/1ps
`include "l1_cache_params.svh"

interface l1_way_if;
	import l1_cache_pkg::*;

	// port A, driven by the fill controller
	set_idx_t a_set;
	logic tag_we;
	tag_entry_t tag_wdata;
	logic line_we;
	line_t line_wdata;

	// port B, driven by the snoop controller
	set_idx_t b_set;
	logic b_inv;

	// registered read data from the way
	tag_entry_t a_tag;
	line_t a_line;
	tag_entry_t b_tag;

	modport ctrl (output a_set, tag_we, tag_wdata, line_we, line_wdata);
	modport snoop (output b_set, b_inv);
	modport way (input a_set, tag_we, tag_wdata, line_we, line_wdata, b_set, b_inv,
		output a_tag, a_line, b_tag);
	modport sel (input a_tag, a_line, b_tag);
endinterface

/* l1_ctrl_pkg.sv */
// Controller state encodings for the fill and snoop machines.
package l1_ctrl_pkg;

	typedef enum logic [3:0] {
		INIT_A, INIT_B, IDLE, CHECK_A, CHECK_B,
		HIT_RESP, FILL_AR, FILL_DATA, FILL_STALL
	} fill_state_e;

	typedef enum logic [1:0] {
		S_IDLE, S_READ, S_CHECK
	} snoop_state_e;

endpackage

/* l1_cache_pkg.sv */
// Storage geometry types shared by the ways, the hit logic and the controllers.
// The address split assumes 32-bit words with byte addressing.
`include "l1_cache_params.svh"

package l1_cache_pkg;

	typedef logic [$clog2(`L1_SETS)-1:0] set_idx_t;
	typedef logic [$clog2(`L1_WORDS)-1:0] word_sel_t;
	typedef logic [`L1_ADDR_W-$clog2(`L1_SETS)-$clog2(`L1_WORDS)-3:0] tag_t;
	typedef logic [$clog2(`L1_WAYS)-1:0] way_idx_t;
	typedef logic [31:0] word_t;

	// byte address split into its cache fields
	typedef struct packed {
		tag_t tag;
		set_idx_t set;
		word_sel_t word;
		logic [1:0] byte_off;
	} addr_fields_t;

	typedef struct packed {
		logic valid;
		tag_t tag;
	} tag_entry_t;

	typedef word_t [`L1_WORDS-1:0] line_t;

endpackage

/* l1_cache_params.svh */
// Cache geometry for the L1 read cache.
// Ways may be 2, 4 or 8. Sets and words per line are fixed by the
// address split in l1_cache_pkg and must stay powers of two.
`ifndef L1_CACHE_PARAMS_SVH
`define L1_CACHE_PARAMS_SVH

// number of ways
`define L1_WAYS 4
// sets per way, one 4k page worth of lines
`define L1_SETS 256
// 32-bit words per line
`define L1_WORDS 4
// byte address width
`define L1_ADDR_W 32

`endif
